// ==== eth_rx_pkg.sv ====
`default_nettype none

package eth_rx_pkg;

	////////////////////////////////////////////////////////////
	// Data path widths

	// One buffer word, packed big endian from the wire
	localparam int word_bits = 32;

	// Count of valid bytes in a word, 1 to 4
	localparam int lane_bits = 3;

	////////////////////////////////////////////////////////////
	// Frame buffer geometry

	localparam int buf_depth = 64;
	localparam int buf_addr_bits = 6;

	////////////////////////////////////////////////////////////
	// GMII symbols and CRC constants

	localparam logic [7:0] gmii_preamble = 8'h55;
	localparam logic [7:0] gmii_sfd = 8'hd5;

	// Reflected form of the 802.3 polynomial
	localparam logic [31:0] crc32_poly = 32'hedb88320;

	// One byte through the reflected CRC, LSB of the byte first
	function automatic logic [31:0] crc32_next(input logic [31:0] crc, input logic [7:0] din);
		logic [31:0] c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ din[i])
				c = (c >> 1) ^ crc32_poly;
			else
				c = c >> 1;
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== crc32_eth.sv ====
`default_nettype none

module crc32_eth
	import eth_rx_pkg::*;
(
	input wire gmii_rx_clk,
	input wire arst_n,

	// Restart at all ones for a new frame
	input wire clear,

	// Fold din into the running CRC
	input wire update,
	input wire [7:0] din,

	// Final FCS in the byte order it appears on the wire
	output logic [31:0] crc
);

	logic [31:0] crc_q;

	////////////////////////////////////////////////////////////
	// CRC state register

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			crc_q <= 32'hffffffff;
		end else if (clear) begin
			crc_q <= 32'hffffffff;
		end else if (update) begin
			crc_q <= crc32_next(crc_q, din);
		end
	end

	////////////////////////////////////////////////////////////
	// Output formatting

	// Low byte of the register goes out first
	// so it lands in the top lane of a packed word
	assign crc = {~crc_q[7:0], ~crc_q[15:8], ~crc_q[23:16], ~crc_q[31:24]};

endmodule

`default_nettype wire

// ==== gmii_rx_parser.sv ====
`default_nettype none

module gmii_rx_parser
	import eth_rx_pkg::*;
(
	input wire gmii_rx_clk,
	input wire arst_n,

	// GMII receive side
	input wire gmii_rx_dv,
	input wire gmii_rx_er,
	input wire [7:0] gmii_rxd,

	// Word stream into the frame buffer
	output logic wr_start,
	output logic wr_strobe,
	output logic [word_bits-1:0] wr_data,
	output logic [lane_bits-1:0] wr_bytes,
	output logic wr_commit,
	output logic wr_drop
);

	typedef enum logic [2:0] {
		st_idle,
		st_preamble,
		st_frame,
		st_verdict,
		st_discard
	} rx_state_t;

	rx_state_t state;

	// Last four bytes seen, possibly the FCS
	logic [31:0] hold;
	logic [2:0] hold_cnt;

	// Partial word being packed from bytes leaving the hold register
	logic [23:0] pack;
	logic [1:0] pack_cnt;

	// Frame flags for the verdict
	logic err_seen;
	logic payload_seen;

	logic crc_clear;
	logic crc_update;
	logic [31:0] crc_calc;

	////////////////////////////////////////////////////////////
	// CRC over bytes leaving the hold register

	// Restart on the SFD
	assign crc_clear = (state == st_preamble) && gmii_rx_dv && !gmii_rx_er &&
		(gmii_rxd == gmii_sfd);

	// A byte only leaves once four newer ones are behind it
	assign crc_update = (state == st_frame) && gmii_rx_dv && (hold_cnt == 3'd4);

	crc32_eth crc32_eth_i (
		.gmii_rx_clk(gmii_rx_clk),
		.arst_n(arst_n),
		.clear(crc_clear),
		.update(crc_update),
		.din(hold[31:24]),
		.crc(crc_calc)
	);

	////////////////////////////////////////////////////////////
	// Byte delay, packing and word output

	always_ff @(posedge gmii_rx_clk) begin
		if ((state == st_frame) && gmii_rx_dv)
			hold <= {hold[23:0], gmii_rxd};

		if (crc_update)
			pack <= {pack[15:0], hold[31:24]};

		// Fourth byte completes a word
		if (crc_update && (pack_cnt == 2'd3)) begin
			wr_data <= {pack, hold[31:24]};
			wr_bytes <= 3'd4;
		end else if ((state == st_frame) && !gmii_rx_dv) begin
			// Leftover bytes go out left aligned
			wr_bytes <= {1'b0, pack_cnt};
			case (pack_cnt)
				2'd1: wr_data <= {pack[7:0], 24'h0};
				2'd2: wr_data <= {pack[15:0], 16'h0};
				2'd3: wr_data <= {pack, 8'h0};
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Receive FSM

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			hold_cnt <= '0;
			pack_cnt <= '0;
			err_seen <= 1'b0;
			payload_seen <= 1'b0;
			wr_start <= 1'b0;
			wr_strobe <= 1'b0;
			wr_commit <= 1'b0;
			wr_drop <= 1'b0;
		end else begin
			// Strobes default low
			wr_start <= 1'b0;
			wr_strobe <= 1'b0;
			wr_commit <= 1'b0;
			wr_drop <= 1'b0;

			case (state)
				st_idle: begin
					// Anything but a clean preamble byte is skipped
					if (gmii_rx_dv) begin
						if (!gmii_rx_er && (gmii_rxd == gmii_preamble))
							state <= st_preamble;
						else
							state <= st_discard;
					end
				end

				st_preamble: begin
					if (!gmii_rx_dv) begin
						state <= st_idle;
					end else if (gmii_rx_er) begin
						state <= st_discard;
					end else if (gmii_rxd == gmii_sfd) begin
						// Frame begins, buffer gets told now
						wr_start <= 1'b1;
						hold_cnt <= '0;
						pack_cnt <= '0;
						err_seen <= 1'b0;
						payload_seen <= 1'b0;
						state <= st_frame;
					end else if (gmii_rxd != gmii_preamble) begin
						state <= st_discard;
					end
				end

				st_frame: begin
					if (gmii_rx_dv) begin
						if (hold_cnt != 3'd4)
							hold_cnt <= hold_cnt + 3'd1;
						if (gmii_rx_er)
							err_seen <= 1'b1;
						if (crc_update) begin
							payload_seen <= 1'b1;
							pack_cnt <= pack_cnt + 2'd1;
							if (pack_cnt == 2'd3)
								wr_strobe <= 1'b1;
						end
					end else begin
						// End of frame, flush any partial word
						if (pack_cnt != 2'd0)
							wr_strobe <= 1'b1;
						state <= st_verdict;
					end
				end

				st_verdict: begin
					// Hold now has the received FCS, CRC is final
					if (payload_seen && !err_seen && (hold == crc_calc))
						wr_commit <= 1'b1;
					else
						wr_drop <= 1'b1;
					state <= st_idle;
				end

				st_discard: begin
					if (!gmii_rx_dv)
						state <= st_idle;
				end

				default: state <= st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// One verdict at a time
	assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		!(wr_commit && wr_drop));

	// Every frame that reached data gets its verdict two cycles after dv drops
	assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		((state == st_frame) && !gmii_rx_dv) |-> ##2 (wr_commit || wr_drop));

endmodule

`default_nettype wire

// ==== rx_frame_buffer.sv ====
`default_nettype none

module rx_frame_buffer
	import eth_rx_pkg::*;
(
	input wire gmii_rx_clk,
	input wire arst_n,

	// Tentative writes from the parser
	input wire wr_start,
	input wire wr_strobe,
	input wire [word_bits-1:0] wr_data,
	input wire [lane_bits-1:0] wr_bytes,
	input wire wr_commit,
	input wire wr_drop,

	// Head of committed data
	input wire rd_strobe,
	output logic avail,
	output logic [word_bits-1:0] rd_data,
	output logic [lane_bits-1:0] rd_bytes,
	output logic rd_last,

	// Frame thrown away for lack of space
	output logic overflow_drop
);

	// Word storage, byte counts and end-of-frame flags
	logic [word_bits-1:0] data_mem [buf_depth];
	logic [lane_bits-1:0] bytes_mem [buf_depth];
	logic [buf_depth-1:0] last_mem;

	// Pointers carry one extra wrap bit
	logic [buf_addr_bits:0] wr_tent;
	logic [buf_addr_bits:0] wr_comm;
	logic [buf_addr_bits:0] rd_ptr;

	// Where the newest word of the current frame went
	logic [buf_addr_bits-1:0] last_addr;

	// Set once this frame hit a full buffer
	logic frame_ovf;

	logic full;
	logic ram_we;
	logic commit_ok;

	////////////////////////////////////////////////////////////
	// Status

	// Full counts tentative words too
	assign full = (wr_tent[buf_addr_bits] != rd_ptr[buf_addr_bits]) &&
		(wr_tent[buf_addr_bits-1:0] == rd_ptr[buf_addr_bits-1:0]);

	// Rest of an overflowed frame is ignored
	assign ram_we = wr_strobe && !full && !frame_ovf;

	// Only a clean frame with at least one word gets published
	assign commit_ok = wr_commit && !frame_ovf && (wr_tent != wr_comm);

	assign avail = (wr_comm != rd_ptr);

	////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge gmii_rx_clk) begin
		if (ram_we) begin
			data_mem[wr_tent[buf_addr_bits-1:0]] <= wr_data;
			bytes_mem[wr_tent[buf_addr_bits-1:0]] <= wr_bytes;
			last_mem[wr_tent[buf_addr_bits-1:0]] <= 1'b0;
			last_addr <= wr_tent[buf_addr_bits-1:0];
		end
		// Mark the final word once the frame is known good
		if (commit_ok)
			last_mem[last_addr] <= 1'b1;
	end

	assign rd_data = data_mem[rd_ptr[buf_addr_bits-1:0]];
	assign rd_bytes = bytes_mem[rd_ptr[buf_addr_bits-1:0]];
	assign rd_last = last_mem[rd_ptr[buf_addr_bits-1:0]];

	////////////////////////////////////////////////////////////
	// Pointer control

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_tent <= '0;
			wr_comm <= '0;
			rd_ptr <= '0;
			frame_ovf <= 1'b0;
			overflow_drop <= 1'b0;
		end else begin
			overflow_drop <= 1'b0;

			if (ram_we)
				wr_tent <= wr_tent + 1'b1;

			if (wr_start)
				frame_ovf <= 1'b0;
			else if (wr_strobe && full)
				frame_ovf <= 1'b1;

			// Rewind on a bad frame or one that did not fit
			if (wr_drop || (wr_commit && frame_ovf)) begin
				wr_tent <= wr_comm;
				frame_ovf <= 1'b0;
			end else if (commit_ok) begin
				wr_comm <= wr_tent;
			end

			if (wr_commit && frame_ovf)
				overflow_drop <= 1'b1;

			if (rd_strobe)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Reader never pops an empty buffer
	assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		rd_strobe |-> avail);

	// Writer never laps the reader
	assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		(buf_addr_bits + 1)'(wr_tent - rd_ptr) <= buf_depth);

endmodule

`default_nettype wire

// ==== rx_frame_reader.sv ====
`default_nettype none

module rx_frame_reader
	import eth_rx_pkg::*;
(
	input wire gmii_rx_clk,
	input wire arst_n,

	// Buffer head
	input wire avail,
	input wire [word_bits-1:0] rd_data,
	input wire [lane_bits-1:0] rd_bytes,
	input wire rd_last,

	// Frame events for the counters
	input wire wr_commit_seen,
	input wire crc_drop_seen,
	input wire overflow_drop,

	output logic rd_strobe,

	// Word stream to the upper layer
	output logic out_valid,
	output logic [word_bits-1:0] out_data,
	output logic [lane_bits-1:0] out_bytes,
	output logic out_first,
	output logic out_last,

	output logic [15:0] frame_count,
	output logic [15:0] crc_err_count,
	output logic [15:0] overflow_count
);

	// Next popped word opens a frame
	logic at_start;
	logic frame_done;

	// Committed frames not yet fully drained
	logic [buf_addr_bits:0] frames_pending;

	// No back-pressure, take every word as soon as it is there
	assign rd_strobe = avail;
	assign frame_done = rd_strobe && rd_last;

	////////////////////////////////////////////////////////////
	// Output word

	always_ff @(posedge gmii_rx_clk) begin
		if (rd_strobe) begin
			out_data <= rd_data;
			out_bytes <= rd_bytes;
		end
	end

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_first <= 1'b0;
			out_last <= 1'b0;
			at_start <= 1'b1;
		end else begin
			out_valid <= rd_strobe;
			out_first <= rd_strobe && at_start;
			out_last <= frame_done;
			if (rd_strobe)
				at_start <= rd_last;
		end
	end

	////////////////////////////////////////////////////////////
	// Counters

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_count <= '0;
			crc_err_count <= '0;
			overflow_count <= '0;
			frames_pending <= '0;
		end else begin
			if (frame_done)
				frame_count <= frame_count + 16'd1;
			if (crc_drop_seen)
				crc_err_count <= crc_err_count + 16'd1;
			if (overflow_drop)
				overflow_count <= overflow_count + 16'd1;

			// Overflowed commits are taken back a cycle later
			frames_pending <= frames_pending
				+ {{buf_addr_bits{1'b0}}, wr_commit_seen}
				- {{buf_addr_bits{1'b0}}, overflow_drop}
				- {{buf_addr_bits{1'b0}}, frame_done};
		end
	end

	// Words only flow for frames the parser committed
	assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		rd_strobe |-> (frames_pending != '0));

endmodule

`default_nettype wire

// ==== gmii_rx_top.sv ====
`default_nettype none

module gmii_rx_top
	import eth_rx_pkg::*;
(
	input wire gmii_rx_clk,
	input wire arst_n,

	input wire gmii_rx_dv,
	input wire gmii_rx_er,
	input wire [7:0] gmii_rxd,

	output logic out_valid,
	output logic [word_bits-1:0] out_data,
	output logic [lane_bits-1:0] out_bytes,
	output logic out_first,
	output logic out_last,

	output logic [15:0] frame_count,
	output logic [15:0] crc_err_count,
	output logic [15:0] overflow_count
);

	////////////////////////////////////////////////////////////
	// Parser to buffer

	logic wr_start;
	logic wr_strobe;
	logic [word_bits-1:0] wr_data;
	logic [lane_bits-1:0] wr_bytes;
	logic wr_commit;
	logic wr_drop;

	// Buffer to reader
	logic avail;
	logic [word_bits-1:0] rd_data;
	logic [lane_bits-1:0] rd_bytes;
	logic rd_last;
	logic rd_strobe;
	logic overflow_drop;

	gmii_rx_parser gmii_rx_parser_i (
		.gmii_rx_clk(gmii_rx_clk),
		.arst_n(arst_n),
		.gmii_rx_dv(gmii_rx_dv),
		.gmii_rx_er(gmii_rx_er),
		.gmii_rxd(gmii_rxd),
		.wr_start(wr_start),
		.wr_strobe(wr_strobe),
		.wr_data(wr_data),
		.wr_bytes(wr_bytes),
		.wr_commit(wr_commit),
		.wr_drop(wr_drop)
	);

	rx_frame_buffer rx_frame_buffer_i (
		.gmii_rx_clk(gmii_rx_clk),
		.arst_n(arst_n),
		.wr_start(wr_start),
		.wr_strobe(wr_strobe),
		.wr_data(wr_data),
		.wr_bytes(wr_bytes),
		.wr_commit(wr_commit),
		.wr_drop(wr_drop),
		.rd_strobe(rd_strobe),
		.avail(avail),
		.rd_data(rd_data),
		.rd_bytes(rd_bytes),
		.rd_last(rd_last),
		.overflow_drop(overflow_drop)
	);

	// Parser drops count as CRC errors
	rx_frame_reader rx_frame_reader_i (
		.gmii_rx_clk(gmii_rx_clk),
		.arst_n(arst_n),
		.avail(avail),
		.rd_data(rd_data),
		.rd_bytes(rd_bytes),
		.rd_last(rd_last),
		.wr_commit_seen(wr_commit),
		.crc_drop_seen(wr_drop),
		.overflow_drop(overflow_drop),
		.rd_strobe(rd_strobe),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_bytes(out_bytes),
		.out_first(out_first),
		.out_last(out_last),
		.frame_count(frame_count),
		.crc_err_count(crc_err_count),
		.overflow_count(overflow_count)
	);

endmodule

`default_nettype wire

// ==== tb_gmii_rx.sv ====
`default_nettype none

module tb_gmii_rx
	import eth_rx_pkg::*;
();

	// Extra cycles allowed for expected words to drain
	localparam int drain_slack = 16;
	// Quiet cycles before counters are read so the 2-cycle verdict has landed
	localparam int settle_cycles = 8;
	localparam int reset_cycles = 16;

	logic gmii_rx_clk = 1'b0;
	logic arst_n;
	logic gmii_rx_dv;
	logic gmii_rx_er;
	logic [7:0] gmii_rxd;

	logic out_valid;
	logic [word_bits-1:0] out_data;
	logic [lane_bits-1:0] out_bytes;
	logic out_first;
	logic out_last;
	logic [15:0] frame_count;
	logic [15:0] crc_err_count;
	logic [15:0] overflow_count;

	// Reference model state for the frame being sent
	logic [31:0] crc_ref;
	logic [7:0] frame_bytes[$];

	// Expected output words, oldest first
	logic [word_bits-1:0] exp_data[$];
	logic [lane_bits-1:0] exp_bytes[$];
	logic exp_first[$];
	logic exp_last[$];
	logic [word_bits-1:0] want_data;
	logic [lane_bits-1:0] want_bytes;
	logic want_first;
	logic want_last;

	// Running totals the counters must match
	logic [15:0] exp_frames;
	logic [15:0] exp_crc_errs;
	logic [15:0] exp_ovfs;

	int errors;
	int checks;
	int tests_run;
	int test_id;
	int test_err_base;
	int test_words;
	logic test_open;
	int cycle_count = 0;
	int cycle_limit = 32'h7fffffff;
	string stim_lines[$];

	// Period of 4
	always #2 gmii_rx_clk = ~gmii_rx_clk;

	gmii_rx_top gmii_rx_top_i (
		.gmii_rx_clk(gmii_rx_clk),
		.arst_n(arst_n),
		.gmii_rx_dv(gmii_rx_dv),
		.gmii_rx_er(gmii_rx_er),
		.gmii_rxd(gmii_rxd),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_bytes(out_bytes),
		.out_first(out_first),
		.out_last(out_last),
		.frame_count(frame_count),
		.crc_err_count(crc_err_count),
		.overflow_count(overflow_count)
	);

	////////////////////////////////////////////////////////////
	// GMII drive helpers

	// Frame byte i of a run depends on every index bit
	function automatic logic [7:0] pattern_byte(input logic [7:0] seed, input logic [15:0] idx);
		return seed + idx[7:0] + idx[15:8];
	endfunction

	task automatic drive_cycle(input logic [7:0] b, input logic dv, input logic er);
		@(negedge gmii_rx_clk);
		gmii_rxd = b;
		gmii_rx_dv = dv;
		gmii_rx_er = er;
	endtask

	// Preamble run then SFD and a fresh reference CRC
	task automatic send_preamble(input int n);
		crc_ref = 32'hffffffff;
		frame_bytes.delete();
		repeat (n) drive_cycle(gmii_preamble, 1'b1, 1'b0);
		drive_cycle(gmii_sfd, 1'b1, 1'b0);
	endtask

	task automatic send_data(input int n, input logic [7:0] seed);
		logic [7:0] b;
		for (int k = 0; k < n; k++) begin
			b = pattern_byte(seed, 16'(k));
			drive_cycle(b, 1'b1, 1'b0);
			crc_ref = crc32_next(crc_ref, b);
			frame_bytes.push_back(b);
		end
	endtask

	// Lone byte, taken into the reference CRC whenever dv is high
	task automatic send_byte(input logic [7:0] b, input logic dv, input logic er);
		drive_cycle(b, dv, er);
		if (dv) begin
			crc_ref = crc32_next(crc_ref, b);
			frame_bytes.push_back(b);
		end
	endtask

	// FCS goes out low byte first
	task automatic send_fcs(input logic corrupt);
		logic [31:0] fcs;
		fcs = ~crc_ref;
		if (corrupt)
			fcs = fcs ^ 32'h1;
		for (int k = 0; k < 4; k++)
			drive_cycle(fcs[8*k +: 8], 1'b1, 1'b0);
	endtask

	// Published check value against the reference CRC
	task automatic check_known_crc(input logic [31:0] known);
		checks++;
		if (~crc_ref !== known) begin
			$display("[ERROR] reference CRC expected %h got %h", known, ~crc_ref);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Expected words

	task automatic expect_word(input logic [31:0] d, input logic [lane_bits-1:0] nb,
		input logic first, input logic last);
		exp_data.push_back(d);
		exp_bytes.push_back(nb);
		exp_first.push_back(first);
		exp_last.push_back(last);
	endtask

	// Bytes packed big endian with a short last word left aligned
	task automatic expect_frame();
		logic [31:0] w;
		int cnt;
		int n;
		n = frame_bytes.size();
		for (int i = 0; i < n; i += 4) begin
			w = '0;
			cnt = 0;
			for (int j = 0; j < 4; j++) begin
				w = w << 8;
				if (i + j < n) begin
					w[7:0] = frame_bytes[i + j];
					cnt++;
				end
			end
			expect_word(w, lane_bits'(cnt), i == 0, i + 4 >= n);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor sampled mid-cycle

	always @(negedge gmii_rx_clk) begin
		if (arst_n && out_valid) begin
			if (exp_data.size() == 0) begin
				$display("Test %0d: output word %h arrived when none was expected",
					test_id, out_data);
				errors++;
			end else begin
				want_data = exp_data.pop_front();
				want_bytes = exp_bytes.pop_front();
				want_first = exp_first.pop_front();
				want_last = exp_last.pop_front();
				checks++;
				test_words++;
				if (out_data !== want_data) begin
					$display("[ERROR] out_data expected %h got %h", want_data, out_data);
					errors++;
				end
				if (out_bytes !== want_bytes) begin
					$display("[ERROR] out_bytes expected %h got %h", want_bytes, out_bytes);
					errors++;
				end
				if (out_first !== want_first) begin
					$display("[ERROR] out_first expected %h got %h", want_first, out_first);
					errors++;
				end
				if (out_last !== want_last) begin
					$display("[ERROR] out_last expected %h got %h", want_last, out_last);
					errors++;
				end
			end
		end
	end

	// Run limit from the stimulus length
	always @(posedge gmii_rx_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test close drains words then reads counters

	task automatic finish_test();
		int bound;
		int waited;
		bound = exp_data.size() + drain_slack;
		waited = 0;
		while (exp_data.size() != 0 && waited < bound) begin
			@(negedge gmii_rx_clk);
			waited++;
		end
		if (exp_data.size() != 0) begin
			$display("Test %0d: %0d expected output words never appeared",
				test_id, exp_data.size());
			errors++;
			exp_data.delete();
			exp_bytes.delete();
			exp_first.delete();
			exp_last.delete();
		end
		repeat (settle_cycles) @(negedge gmii_rx_clk);
		checks += 3;
		if (frame_count !== exp_frames) begin
			$display("[ERROR] frame_count expected %h got %h", exp_frames, frame_count);
			errors++;
		end
		if (crc_err_count !== exp_crc_errs) begin
			$display("[ERROR] crc_err_count expected %h got %h", exp_crc_errs, crc_err_count);
			errors++;
		end
		if (overflow_count !== exp_ovfs) begin
			$display("[ERROR] overflow_count expected %h got %h", exp_ovfs, overflow_count);
			errors++;
		end
		$display("Test %0d finished: %0d words, %0d errors",
			test_id, test_words, errors - test_err_base);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int fd;
		int nf;
		int pre_len;
		int total;
		string line;
		logic [7:0] tag;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;

		arst_n = 1'b0;
		gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		gmii_rxd = 8'h00;
		errors = 0;
		checks = 0;
		tests_run = 0;
		test_id = 0;
		test_err_base = 0;
		test_words = 0;
		test_open = 1'b0;
		exp_frames = '0;
		exp_crc_errs = '0;
		exp_ovfs = '0;
		crc_ref = 32'hffffffff;

		// Comment and blank lines dropped
		fd = $fopen("gmii_rx_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open gmii_rx_stimulus.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				nf = $fgets(line, fd);
				if (line.len() > 0 && line[0] != "#" && line[0] != "\n")
					stim_lines.push_back(line);
			end
			$fclose(fd);
		end

		// Cycle budget over bytes, idles, drains and settles
		total = reset_cycles;
		pre_len = 0;
		foreach (stim_lines[i]) begin
			nf = $sscanf(stim_lines[i], "%c %h %h %h %h", tag, a, b, c, d);
			case (tag)
				"T": total += settle_cycles + drain_slack;
				"P": begin
					total += a + 1;
					pre_len = 0;
				end
				"B": total += 1;
				"D": begin
					total += a;
					pre_len += a;
				end
				"F": total += 4;
				"I": total += a;
				"W": total += 1;
				"X": total += pre_len / 4 + 1;
				default: ;
			endcase
		end
		cycle_limit = total + 200;

		repeat (reset_cycles) @(posedge gmii_rx_clk);
		@(negedge gmii_rx_clk);
		arst_n = 1'b1;

		foreach (stim_lines[i]) begin
			nf = $sscanf(stim_lines[i], "%c %h %h %h %h", tag, a, b, c, d);
			case (tag)
				"T": begin
					if (test_open)
						finish_test();
					test_open = 1'b1;
					tests_run++;
					test_id = a;
					test_words = 0;
					test_err_base = errors;
					exp_frames = exp_frames + b[15:0];
					exp_crc_errs = exp_crc_errs + c[15:0];
					exp_ovfs = exp_ovfs + d[15:0];
				end
				"P": send_preamble(a);
				"B": send_byte(a[7:0], b[0], c[0]);
				"D": send_data(a, b[7:0]);
				"K": check_known_crc(a);
				"F": send_fcs(a[0]);
				"I": begin
					repeat (a) drive_cycle(8'h00, 1'b0, 1'b0);
				end
				"W": expect_word(a, b[lane_bits-1:0], c[0], d[0]);
				"X": expect_frame();
				default: begin
					$display("Stimulus line %0d has an unknown record tag", i);
					errors++;
				end
			endcase
		end
		if (test_open)
			finish_test();

		$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== gmii_rx_stimulus.txt ====
# T id frames crc_errs overflows | P n | B byte dv er | D n seed | K crc | F corrupt | I n
# W data bytes first last | X = words of the current frame's data; all numbers hex
I 8
T 1 1 0 0
P 7
D c 10
F 0
W 10111213 4 1 0
W 14151617 4 0 0
W 18191a1b 4 0 1
I c
T 2 2 0 0
P 7
D 41 40
F 0
X
I c
P 7
D 9 31
K cbf43926
F 0
W 31323334 4 1 0
W 35363738 4 0 0
W 39000000 1 0 1
I c
T 3 1 1 0
P 7
D 10 80
F 1
I c
P 7
D 14 a0
F 0
X
I c
T 4 0 0 0
B 55 1 0
B 55 1 0
B 5a 1 0
D 8 c0
F 0
I c
B 55 1 0
B 55 1 1
B d5 1 0
D 8 c8
F 0
I c
T 5 0 1 0
P 7
D 8 20
B 77 1 1
D 8 30
F 0
I c
T 6 1 0 1
P 7
D 12c 05
F 0
I c
P 7
D 18 60
F 0
X
I c

// ==== gmii_rx.f ====
eth_rx_pkg.sv
crc32_eth.sv
gmii_rx_parser.sv
rx_frame_buffer.sv
rx_frame_reader.sv
gmii_rx_top.sv
tb_gmii_rx.sv
